// ==== src/eth_ctrl_pkg.sv ====
package eth_ctrl_pkg;

  localparam int eth_data_width = 32;
  localparam int eth_keep_width = eth_data_width / 8;
  localparam int eth_addr_width = 14;
  localparam int eth_max_mtu    = 2048;

  // sized to hold eth_max_mtu itself.
  typedef logic [$clog2(eth_max_mtu+1)-1:0] pkt_size_t;
  typedef logic [$clog2(eth_max_mtu)-1:0]   pkt_addr_t;

  // register map, byte offsets on the register port.
  typedef enum logic [eth_addr_width-1:0] {
    reg_rx_buf     = 14'h0000,
    reg_tx_buf     = 14'h0800,
    reg_rx_size    = 14'h1000,
    reg_rx_ack     = 14'h1004,
    reg_tx_size    = 14'h1008,
    reg_tx_send    = 14'h100C,
    reg_rx_pending = 14'h1010,
    reg_tx_pending = 14'h1014,
    reg_rx_int_en  = 14'h1018,
    reg_tx_int_en  = 14'h101C,
    reg_debug      = 14'h1020
  } eth_reg_e;

  // user flags a bad frame on receive.
  typedef struct packed {
    logic [eth_data_width-1:0] data;
    logic [eth_keep_width-1:0] keep;
    logic                      last;
    logic                      user;
  } eth_beat_t;

  typedef struct packed {
    logic                      valid;
    pkt_addr_t                 addr;
    logic [eth_data_width-1:0] data;
    logic [eth_keep_width-1:0] mask;
  } pkt_wr_t;

  typedef enum logic {
    tx_idle,
    tx_stream
  } tx_state_e;

  typedef enum logic [1:0] {
    rx_collect,
    rx_hold,
    rx_drop
  } rx_state_e;

endpackage

// ==== src/ethernet_control_unit.sv ====
`timescale 1ns/100ps

module ethernet_control_unit #(
    parameter int eth_mtu_p = 2048
)
(
    input  logic                                      clk_i
  , input  logic                                      rst_n_i

  , input  logic [eth_ctrl_pkg::eth_addr_width-1:0]   addr_i
  , input  logic                                      write_en_i
  , input  logic                                      read_en_i
  , input  logic [eth_ctrl_pkg::eth_keep_width-1:0]   write_mask_i
  , input  logic [eth_ctrl_pkg::eth_data_width-1:0]   write_data_i
  , output logic [eth_ctrl_pkg::eth_data_width-1:0]   read_data_o

  , output eth_ctrl_pkg::pkt_wr_t                     tx_wr_o
  , output eth_ctrl_pkg::pkt_size_t                   tx_size_o
  , output logic                                      tx_size_valid_o
  , output logic                                      tx_send_o
  , output logic                                      rx_ack_o
  , output eth_ctrl_pkg::pkt_addr_t                   rx_raddr_o
  , output logic                                      rx_rvalid_o
  , output logic                                      tx_int_clear_o
  , output logic                                      rx_int_en_o
  , output logic                                      rx_int_en_valid_o
  , output logic                                      tx_int_en_o
  , output logic                                      tx_int_en_valid_o

  , input  logic [eth_ctrl_pkg::eth_data_width-1:0]   rx_rdata_i
  , input  logic                                      rx_avail_i
  , input  eth_ctrl_pkg::pkt_size_t                   rx_size_i
  , input  logic [7:0]                                rx_drop_count_i
  , input  logic                                      rx_pending_i
  , input  logic                                      tx_pending_i
);

  localparam int paddr_w_lp = $bits(eth_ctrl_pkg::pkt_addr_t);

  logic [eth_ctrl_pkg::eth_addr_width-1:0] rx_off;
  logic [eth_ctrl_pkg::eth_addr_width-1:0] tx_off;
  logic                                    in_rx_buf;
  logic                                    in_tx_buf;

  logic [eth_ctrl_pkg::eth_data_width-1:0] reg_rdata;
  logic [eth_ctrl_pkg::eth_data_width-1:0] reg_rdata_q;
  logic                                    sel_buf_q;

  // offsets wrap below the base, so one compare bounds each window.
  assign rx_off    = addr_i - eth_ctrl_pkg::reg_rx_buf;
  assign tx_off    = addr_i - eth_ctrl_pkg::reg_tx_buf;
  assign in_rx_buf = rx_off < eth_ctrl_pkg::eth_addr_width'(eth_mtu_p);
  assign in_tx_buf = tx_off < eth_ctrl_pkg::eth_addr_width'(eth_mtu_p);

  // transmit buffer writes, word aligned.
  assign tx_wr_o.valid = write_en_i && in_tx_buf;
  assign tx_wr_o.addr  = {tx_off[paddr_w_lp-1:2], 2'b00};
  assign tx_wr_o.data  = write_data_i;
  assign tx_wr_o.mask  = write_mask_i;

  assign tx_size_o       = write_data_i[$bits(eth_ctrl_pkg::pkt_size_t)-1:0];
  assign tx_size_valid_o = write_en_i && (addr_i == eth_ctrl_pkg::reg_tx_size);
  assign tx_send_o       = write_en_i && (addr_i == eth_ctrl_pkg::reg_tx_send);
  assign rx_ack_o        = write_en_i && (addr_i == eth_ctrl_pkg::reg_rx_ack);
  assign tx_int_clear_o  = write_en_i && (addr_i == eth_ctrl_pkg::reg_tx_pending);

  assign rx_int_en_o       = write_data_i[0];
  assign rx_int_en_valid_o = write_en_i && (addr_i == eth_ctrl_pkg::reg_rx_int_en);
  assign tx_int_en_o       = write_data_i[0];
  assign tx_int_en_valid_o = write_en_i && (addr_i == eth_ctrl_pkg::reg_tx_int_en);

  // receive buffer reads are registered inside the receiver.
  assign rx_raddr_o  = {rx_off[paddr_w_lp-1:2], 2'b00};
  assign rx_rvalid_o = read_en_i && in_rx_buf;

  always_comb begin
    reg_rdata = '0;
    case (addr_i)
      eth_ctrl_pkg::reg_rx_size: begin
        if (rx_avail_i) begin
          reg_rdata = eth_ctrl_pkg::eth_data_width'(rx_size_i);
        end
      end
      eth_ctrl_pkg::reg_rx_pending: reg_rdata = eth_ctrl_pkg::eth_data_width'(rx_pending_i);
      eth_ctrl_pkg::reg_tx_pending: reg_rdata = eth_ctrl_pkg::eth_data_width'(tx_pending_i);
      eth_ctrl_pkg::reg_debug:      reg_rdata = eth_ctrl_pkg::eth_data_width'(rx_drop_count_i);
      default:                      reg_rdata = '0;
    endcase
  end

  // both sources hold their value until the next read.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_buf_q   <= 1'b0;
      reg_rdata_q <= '0;
    end else if (read_en_i) begin
      sel_buf_q   <= in_rx_buf;
      reg_rdata_q <= reg_rdata;
    end
  end

  assign read_data_o = sel_buf_q ? rx_rdata_i : reg_rdata_q;

endmodule

// ==== src/ethernet_sender.sv ====
`timescale 1ns/100ps

module ethernet_sender #(
    parameter int eth_mtu_p = 2048
)
(
    input  logic                                      clk_i
  , input  logic                                      rst_n_i

  , input  eth_ctrl_pkg::pkt_wr_t                     tx_wr_i
  , input  eth_ctrl_pkg::pkt_size_t                   tx_size_i
  , input  logic                                      tx_size_valid_i
  , input  logic                                      tx_send_i
  , input  logic                                      tx_ready_i

  , output logic                                      tx_free_o
  , output eth_ctrl_pkg::eth_beat_t                   tx_beat_o
  , output logic                                      tx_valid_o
);

  localparam int word_aw_lp = $clog2(eth_mtu_p/4);
  localparam int cnt_w_lp   = $bits(eth_ctrl_pkg::pkt_size_t) - 2;

  logic [eth_ctrl_pkg::eth_data_width-1:0] buf_mem [eth_mtu_p/4];

  eth_ctrl_pkg::tx_state_e state_q;
  eth_ctrl_pkg::pkt_size_t tx_size_q;
  eth_ctrl_pkg::pkt_size_t size_m1;
  logic [cnt_w_lp-1:0]     beat_cnt_q;
  logic                    is_last;

  always_ff @(posedge clk_i) begin
    if (tx_wr_i.valid) begin
      for (int b = 0; b < eth_ctrl_pkg::eth_keep_width; b++) begin
        if (tx_wr_i.mask[b]) begin
          buf_mem[tx_wr_i.addr[2 +: word_aw_lp]][8*b +: 8] <= tx_wr_i.data[8*b +: 8];
        end
      end
    end
  end

  // index of the final word is (length - 1) / 4.
  assign size_m1 = tx_size_q - 1'b1;
  assign is_last = beat_cnt_q == size_m1[cnt_w_lp+1:2];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= eth_ctrl_pkg::tx_idle;
      tx_size_q  <= '0;
      beat_cnt_q <= '0;
    end else begin
      if (tx_size_valid_i) begin
        tx_size_q <= tx_size_i;
      end
      case (state_q)
        eth_ctrl_pkg::tx_idle: begin
          if (tx_send_i && (tx_size_q != '0)) begin
            state_q    <= eth_ctrl_pkg::tx_stream;
            beat_cnt_q <= '0;
          end
        end
        eth_ctrl_pkg::tx_stream: begin
          if (tx_ready_i) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
            if (is_last) begin
              state_q <= eth_ctrl_pkg::tx_idle;
            end
          end
        end
        default: state_q <= eth_ctrl_pkg::tx_idle;
      endcase
    end
  end

  always_comb begin
    tx_beat_o.data = buf_mem[beat_cnt_q[word_aw_lp-1:0]];
    tx_beat_o.keep = '1;
    tx_beat_o.last = is_last;
    tx_beat_o.user = 1'b0;
    if (is_last) begin
      case (tx_size_q[1:0])
        2'd1:    tx_beat_o.keep = 4'b0001;
        2'd2:    tx_beat_o.keep = 4'b0011;
        2'd3:    tx_beat_o.keep = 4'b0111;
        default: tx_beat_o.keep = 4'b1111;
      endcase
    end
  end

  assign tx_valid_o = state_q == eth_ctrl_pkg::tx_stream;
  assign tx_free_o  = state_q == eth_ctrl_pkg::tx_idle;

endmodule

// ==== src/ethernet_receiver.sv ====
`timescale 1ns/100ps

module ethernet_receiver #(
    parameter int eth_mtu_p = 2048
)
(
    input  logic                                      clk_i
  , input  logic                                      rst_n_i

  , input  eth_ctrl_pkg::eth_beat_t                   rx_beat_i
  , input  logic                                      rx_valid_i
  , input  logic                                      rx_ack_i
  , input  eth_ctrl_pkg::pkt_addr_t                   rx_raddr_i
  , input  logic                                      rx_rvalid_i

  , output logic                                      rx_ready_o
  , output logic                                      rx_avail_o
  , output eth_ctrl_pkg::pkt_size_t                   rx_size_o
  , output logic [eth_ctrl_pkg::eth_data_width-1:0]   rx_rdata_o
  , output logic [7:0]                                rx_drop_count_o
);

  localparam int word_aw_lp = $clog2(eth_mtu_p/4);

  logic [eth_ctrl_pkg::eth_data_width-1:0] buf_mem [eth_mtu_p/4];

  eth_ctrl_pkg::rx_state_e state_q;
  eth_ctrl_pkg::pkt_size_t rx_len_q;
  eth_ctrl_pkg::pkt_size_t beat_bytes;
  eth_ctrl_pkg::pkt_size_t new_len;
  logic [7:0]              drop_cnt_q;
  logic                    accept;
  logic                    collect;
  logic                    too_long;
  logic                    drop_evt;

  assign rx_ready_o = state_q != eth_ctrl_pkg::rx_hold;
  assign accept     = rx_valid_i && rx_ready_o;
  assign collect    = state_q == eth_ctrl_pkg::rx_collect;

  always_comb begin
    beat_bytes = '0;
    for (int b = 0; b < eth_ctrl_pkg::eth_keep_width; b++) begin
      beat_bytes = beat_bytes + rx_beat_i.keep[b];
    end
  end

  assign new_len  = rx_len_q + beat_bytes;
  assign too_long = new_len > eth_ctrl_pkg::pkt_size_t'(eth_mtu_p);
  assign drop_evt = accept && collect && (too_long || (rx_beat_i.last && rx_beat_i.user));

  // beats land at the byte offset collected so far.
  always_ff @(posedge clk_i) begin
    if (accept && collect && !too_long) begin
      buf_mem[rx_len_q[2 +: word_aw_lp]] <= rx_beat_i.data;
    end
    if (rx_rvalid_i) begin
      rx_rdata_o <= buf_mem[rx_raddr_i[2 +: word_aw_lp]];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= eth_ctrl_pkg::rx_collect;
      rx_len_q   <= '0;
      drop_cnt_q <= '0;
    end else begin
      case (state_q)
        eth_ctrl_pkg::rx_collect: begin
          if (accept) begin
            if (rx_beat_i.last) begin
              rx_len_q <= '0;
              if (!rx_beat_i.user && !too_long) begin
                state_q  <= eth_ctrl_pkg::rx_hold;
                rx_len_q <= new_len;
              end
            end else if (too_long) begin
              state_q  <= eth_ctrl_pkg::rx_drop;
              rx_len_q <= '0;
            end else begin
              rx_len_q <= new_len;
            end
          end
        end
        eth_ctrl_pkg::rx_hold: begin
          if (rx_ack_i) begin
            state_q  <= eth_ctrl_pkg::rx_collect;
            rx_len_q <= '0;
          end
        end
        eth_ctrl_pkg::rx_drop: begin
          // swallow the rest of an oversize frame.
          if (accept && rx_beat_i.last) begin
            state_q <= eth_ctrl_pkg::rx_collect;
          end
        end
        default: state_q <= eth_ctrl_pkg::rx_collect;
      endcase
      if (drop_evt && (drop_cnt_q != 8'hFF)) begin
        drop_cnt_q <= drop_cnt_q + 8'd1;
      end
    end
  end

  assign rx_avail_o      = state_q == eth_ctrl_pkg::rx_hold;
  assign rx_size_o       = rx_len_q;
  assign rx_drop_count_o = drop_cnt_q;

endmodule

// ==== src/interrupt_control_unit.sv ====
`timescale 1ns/100ps

module interrupt_control_unit (
    input  logic clk_i
  , input  logic rst_n_i

  , input  logic rx_avail_i
  , input  logic tx_free_i
  , input  logic tx_int_clear_i
  , input  logic rx_int_en_i
  , input  logic rx_int_en_valid_i
  , input  logic tx_int_en_i
  , input  logic tx_int_en_valid_i

  , output logic rx_pending_o
  , output logic tx_pending_o
  , output logic rx_interrupt_o
  , output logic tx_interrupt_o
);

  logic tx_free_q;
  logic rx_en_q;
  logic tx_en_q;

  // the sender is idle out of reset, so no edge is seen then.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_free_q      <= 1'b1;
      rx_pending_o   <= 1'b0;
      tx_pending_o   <= 1'b0;
      rx_en_q        <= 1'b0;
      tx_en_q        <= 1'b0;
      rx_interrupt_o <= 1'b0;
      tx_interrupt_o <= 1'b0;
    end else begin
      tx_free_q    <= tx_free_i;
      rx_pending_o <= rx_avail_i;
      if (tx_free_i && !tx_free_q) begin
        tx_pending_o <= 1'b1;
      end else if (tx_int_clear_i) begin
        tx_pending_o <= 1'b0;
      end
      if (rx_int_en_valid_i) begin
        rx_en_q <= rx_int_en_i;
      end
      if (tx_int_en_valid_i) begin
        tx_en_q <= tx_int_en_i;
      end
      rx_interrupt_o <= rx_pending_o && rx_en_q;
      tx_interrupt_o <= tx_pending_o && tx_en_q;
    end
  end

endmodule

// ==== src/ethernet_controller.sv ====
`timescale 1ns/100ps

module ethernet_controller #(
    parameter int eth_mtu_p = 2048
)
(
    input  logic                                      clk_i
  , input  logic                                      rst_n_i

  , input  logic [eth_ctrl_pkg::eth_addr_width-1:0]   addr_i
  , input  logic                                      write_en_i
  , input  logic                                      read_en_i
  , input  logic [eth_ctrl_pkg::eth_keep_width-1:0]   write_mask_i
  , input  logic [eth_ctrl_pkg::eth_data_width-1:0]   write_data_i
  , output logic [eth_ctrl_pkg::eth_data_width-1:0]   read_data_o

  , output logic                                      rx_interrupt_o
  , output logic                                      tx_interrupt_o

  , output eth_ctrl_pkg::eth_beat_t                   tx_beat_o
  , output logic                                      tx_valid_o
  , input  logic                                      tx_ready_i

  , input  eth_ctrl_pkg::eth_beat_t                   rx_beat_i
  , input  logic                                      rx_valid_i
  , output logic                                      rx_ready_o
);

  eth_ctrl_pkg::pkt_wr_t   tx_wr;
  eth_ctrl_pkg::pkt_size_t tx_size;
  logic                    tx_size_valid;
  logic                    tx_send;
  logic                    tx_free;

  logic                                    rx_ack;
  eth_ctrl_pkg::pkt_addr_t                 rx_raddr;
  logic                                    rx_rvalid;
  logic [eth_ctrl_pkg::eth_data_width-1:0] rx_rdata;
  logic                                    rx_avail;
  eth_ctrl_pkg::pkt_size_t                 rx_size;
  logic [7:0]                              rx_drop_count;

  logic tx_int_clear;
  logic rx_int_en;
  logic rx_int_en_valid;
  logic tx_int_en;
  logic tx_int_en_valid;
  logic rx_pending;
  logic tx_pending;

  ethernet_control_unit #(
    .eth_mtu_p(eth_mtu_p)
  ) control_unit (
     .clk_i
    ,.rst_n_i
    ,.addr_i
    ,.write_en_i
    ,.read_en_i
    ,.write_mask_i
    ,.write_data_i
    ,.read_data_o
    ,.tx_wr_o(tx_wr)
    ,.tx_size_o(tx_size)
    ,.tx_size_valid_o(tx_size_valid)
    ,.tx_send_o(tx_send)
    ,.rx_ack_o(rx_ack)
    ,.rx_raddr_o(rx_raddr)
    ,.rx_rvalid_o(rx_rvalid)
    ,.tx_int_clear_o(tx_int_clear)
    ,.rx_int_en_o(rx_int_en)
    ,.rx_int_en_valid_o(rx_int_en_valid)
    ,.tx_int_en_o(tx_int_en)
    ,.tx_int_en_valid_o(tx_int_en_valid)
    ,.rx_rdata_i(rx_rdata)
    ,.rx_avail_i(rx_avail)
    ,.rx_size_i(rx_size)
    ,.rx_drop_count_i(rx_drop_count)
    ,.rx_pending_i(rx_pending)
    ,.tx_pending_i(tx_pending)
  );

  ethernet_sender #(
    .eth_mtu_p(eth_mtu_p)
  ) sender (
     .clk_i
    ,.rst_n_i
    ,.tx_wr_i(tx_wr)
    ,.tx_size_i(tx_size)
    ,.tx_size_valid_i(tx_size_valid)
    ,.tx_send_i(tx_send)
    ,.tx_ready_i
    ,.tx_free_o(tx_free)
    ,.tx_beat_o
    ,.tx_valid_o
  );

  ethernet_receiver #(
    .eth_mtu_p(eth_mtu_p)
  ) receiver (
     .clk_i
    ,.rst_n_i
    ,.rx_beat_i
    ,.rx_valid_i
    ,.rx_ack_i(rx_ack)
    ,.rx_raddr_i(rx_raddr)
    ,.rx_rvalid_i(rx_rvalid)
    ,.rx_ready_o
    ,.rx_avail_o(rx_avail)
    ,.rx_size_o(rx_size)
    ,.rx_rdata_o(rx_rdata)
    ,.rx_drop_count_o(rx_drop_count)
  );

  interrupt_control_unit interrupt_unit (
     .clk_i
    ,.rst_n_i
    ,.rx_avail_i(rx_avail)
    ,.tx_free_i(tx_free)
    ,.tx_int_clear_i(tx_int_clear)
    ,.rx_int_en_i(rx_int_en)
    ,.rx_int_en_valid_i(rx_int_en_valid)
    ,.tx_int_en_i(tx_int_en)
    ,.tx_int_en_valid_i(tx_int_en_valid)
    ,.rx_pending_o(rx_pending)
    ,.tx_pending_o(tx_pending)
    ,.rx_interrupt_o
    ,.tx_interrupt_o
  );

endmodule

// ==== dv/ethernet_controller_tb.sv ====
`timescale 1ns/100ps

module ethernet_controller_tb;

  localparam int period_lp = 40;
  localparam int mtu_lp    = 2048;

  typedef enum logic [2:0] {
    op_write,
    op_read,
    op_send,
    op_inject,
    op_offer,
    op_irq
  } step_kind_e;

  // inject flags are bit 0 bad user, bit 1 good frame, bit 2 reuse the offered frame.
  // read flag bit 0 takes the expected word from the receive model.
  typedef struct packed {
    step_kind_e                              kind;
    logic [eth_ctrl_pkg::eth_addr_width-1:0] addr;
    logic [31:0]                             data;
    logic [3:0]                              mask;
    logic [11:0]                             len;
    logic [2:0]                              flags;
  } step_t;

  logic                                    clk_i;
  logic                                    rst_n_i;
  logic [eth_ctrl_pkg::eth_addr_width-1:0] addr_i;
  logic                                    write_en_i;
  logic                                    read_en_i;
  logic [eth_ctrl_pkg::eth_keep_width-1:0] write_mask_i;
  logic [eth_ctrl_pkg::eth_data_width-1:0] write_data_i;
  logic [eth_ctrl_pkg::eth_data_width-1:0] read_data_o;
  logic                                    rx_interrupt_o;
  logic                                    tx_interrupt_o;
  eth_ctrl_pkg::eth_beat_t                 tx_beat_o;
  logic                                    tx_valid_o;
  logic                                    tx_ready_i;
  eth_ctrl_pkg::eth_beat_t                 rx_beat_i;
  logic                                    rx_valid_i;
  logic                                    rx_ready_o;

  step_t       steps[$];
  logic [31:0] tx_model [mtu_lp/4];
  logic [31:0] rx_model [mtu_lp/4];
  logic [31:0] frame_words [mtu_lp/2];
  logic [31:0] lcg_state;
  int          errors;
  int          checks;

  ethernet_controller #(
    .eth_mtu_p(mtu_lp)
  ) dut_i (
     .clk_i
    ,.rst_n_i
    ,.addr_i
    ,.write_en_i
    ,.read_en_i
    ,.write_mask_i
    ,.write_data_i
    ,.read_data_o
    ,.rx_interrupt_o
    ,.tx_interrupt_o
    ,.tx_beat_o
    ,.tx_valid_o
    ,.tx_ready_i
    ,.rx_beat_i
    ,.rx_valid_i
    ,.rx_ready_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(period_lp/2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // last beat keeps L mod 4 bytes, or all four.
  function automatic logic [3:0] last_keep(int len);
    return (len % 4 == 0) ? 4'hF : 4'((1 << (len % 4)) - 1);
  endfunction

  function automatic eth_ctrl_pkg::eth_beat_t frame_beat(int idx, int len, logic bad);
    eth_ctrl_pkg::eth_beat_t b;
    int                      nb;
    nb     = (len + 3) / 4;
    b.data = frame_words[idx];
    b.last = (idx == nb - 1);
    b.keep = b.last ? last_keep(len) : 4'hF;
    b.user = bad && b.last;
    return b;
  endfunction

  task automatic add_step(step_kind_e kind, int addr, int data, int mask, int len, int flags);
    step_t s;
    s.kind  = kind;
    s.addr  = 14'(addr);
    s.data  = 32'(data);
    s.mask  = 4'(mask);
    s.len   = 12'(len);
    s.flags = 3'(flags);
    steps.push_back(s);
  endtask

  task automatic check_word(input logic [eth_ctrl_pkg::eth_data_width-1:0] got,
                            input logic [eth_ctrl_pkg::eth_data_width-1:0] exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s returned %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_beat(input eth_ctrl_pkg::eth_beat_t got,
                            input eth_ctrl_pkg::eth_beat_t exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %h/%b/%b/%b, expected %h/%b/%b/%b", $time, what,
               got.data, got.keep, got.last, got.user, exp.data, exp.keep, exp.last, exp.user);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic write_register(input logic [13:0] addr, input logic [31:0] data,
                                input logic [3:0] mask);
    @(posedge clk_i);
    addr_i       <= addr;
    write_data_i <= data;
    write_mask_i <= mask;
    write_en_i   <= 1'b1;
    @(posedge clk_i);
    write_en_i   <= 1'b0;
  endtask

  task automatic read_register(input logic [13:0] addr, output logic [31:0] data);
    @(posedge clk_i);
    addr_i    <= addr;
    read_en_i <= 1'b1;
    @(posedge clk_i);
    read_en_i <= 1'b0;
    @(negedge clk_i);
    data = read_data_o;
  endtask

  task automatic send_frame(input int len);
    eth_ctrl_pkg::eth_beat_t exp;
    logic [31:0]             r;
    int                      nbeats;
    int                      idx;
    nbeats = (len + 3) / 4;
    idx    = 0;
    write_register(eth_ctrl_pkg::reg_tx_size, 32'(len), 4'hF);
    write_register(eth_ctrl_pkg::reg_tx_send, 32'h0, 4'hF);
    @(negedge clk_i);
    check_flag(tx_valid_o, 1'b1, "tx_valid_o on the cycle after send");
    while (idx < nbeats) begin
      @(posedge clk_i);
      r = lcg_next();
      tx_ready_i <= r[16];
      @(negedge clk_i);
      exp.data = tx_model[idx];
      exp.last = (idx == nbeats - 1);
      exp.keep = exp.last ? last_keep(len) : 4'hF;
      exp.user = 1'b0;
      check_flag(tx_valid_o, 1'b1, "tx_valid_o during frame");
      check_beat(tx_beat_o, exp, $sformatf("tx beat %0d", idx));
      if (tx_ready_i) begin
        idx++;
      end
    end
    @(posedge clk_i);
    tx_ready_i <= 1'b0;
    @(negedge clk_i);
    check_flag(tx_valid_o, 1'b0, "tx_valid_o after last beat");
  endtask

  task automatic build_frame(input int len);
    int i;
    for (i = 0; i < (len + 3) / 4; i++) begin
      frame_words[i] = lcg_next();
    end
  endtask

  // present the first beat and hold it while the receiver is busy.
  task automatic offer_frame(input int len);
    build_frame(len);
    @(posedge clk_i);
    rx_valid_i <= 1'b1;
    rx_beat_i  <= frame_beat(0, len, 1'b0);
    repeat (8) begin
      @(negedge clk_i);
      check_flag(rx_ready_o, 1'b0, "rx_ready_o while a frame is held");
    end
  endtask

  task automatic inject_frame(input int len, input logic [2:0] flags);
    int   nb;
    int   i;
    int   wait_cnt;
    logic stalled;
    nb      = (len + 3) / 4;
    stalled = 1'b0;
    if (!flags[2]) begin
      build_frame(len);
    end
    for (i = 0; i < nb && !stalled; i++) begin
      if (!(flags[2] && i == 0)) begin
        @(posedge clk_i);
        rx_valid_i <= 1'b1;
        rx_beat_i  <= frame_beat(i, len, flags[0]);
      end
      wait_cnt = 0;
      @(negedge clk_i);
      while (!rx_ready_o && wait_cnt < 100) begin
        @(negedge clk_i);
        wait_cnt++;
      end
      if (!rx_ready_o) begin
        errors++;
        $display("receive stream did not accept beat %0d within 100 cycles", i);
        stalled = 1'b1;
      end
    end
    @(posedge clk_i);
    rx_valid_i <= 1'b0;
    if (flags[1]) begin
      for (i = 0; i < nb; i++) begin
        rx_model[i] = frame_words[i];
      end
    end
  endtask

  // both outputs settle two cycles after their event.
  task automatic sample_interrupts(input logic [1:0] exp);
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_flag(tx_interrupt_o, exp[1], "tx_interrupt_o");
    check_flag(rx_interrupt_o, exp[0], "rx_interrupt_o");
  endtask

  task automatic apply_step(input step_t s);
    logic [31:0] got;
    logic [31:0] exp;
    int          w;
    int          b;
    case (s.kind)
      op_write: begin
        write_register(s.addr, s.data, s.mask);
        if (s.addr >= eth_ctrl_pkg::reg_tx_buf && s.addr < eth_ctrl_pkg::reg_tx_buf + mtu_lp) begin
          w = (s.addr - eth_ctrl_pkg::reg_tx_buf) / 4;
          for (b = 0; b < 4; b++) begin
            if (s.mask[b]) begin
              tx_model[w][8*b +: 8] = s.data[8*b +: 8];
            end
          end
        end
      end
      op_read: begin
        read_register(s.addr, got);
        exp = s.flags[0] ? rx_model[s.addr / 4] : s.data;
        check_word(got, exp, $sformatf("read of %h", s.addr));
      end
      op_send:   send_frame(s.len);
      op_inject: inject_frame(s.len, s.flags);
      op_offer:  offer_frame(s.len);
      default:   sample_interrupts(s.data[1:0]);
    endcase
  endtask

  task automatic load_table();
    // reset values.
    add_step(op_read, eth_ctrl_pkg::reg_rx_size, 0, 0, 0, 0);
    add_step(op_read, eth_ctrl_pkg::reg_rx_pending, 0, 0, 0, 0);
    add_step(op_read, eth_ctrl_pkg::reg_tx_pending, 0, 0, 0, 0);
    add_step(op_read, eth_ctrl_pkg::reg_debug, 0, 0, 0, 0);
    // transmit framing with a partial mask over word 1.
    add_step(op_write, 'h0800, 'h11223344, 'hF, 0, 0);
    add_step(op_write, 'h0804, 'h55667788, 'hF, 0, 0);
    add_step(op_write, 'h0804, 'hAABBCCDD, 'h5, 0, 0);
    add_step(op_write, eth_ctrl_pkg::reg_tx_int_en, 1, 'hF, 0, 0);
    add_step(op_send, 0, 0, 0, 7, 0);
    add_step(op_irq, 0, 'b10, 0, 0, 0);
    add_step(op_write, eth_ctrl_pkg::reg_tx_pending, 0, 'hF, 0, 0);
    add_step(op_irq, 0, 'b00, 0, 0, 0);
    add_step(op_write, eth_ctrl_pkg::reg_tx_int_en, 0, 'hF, 0, 0);
    add_step(op_send, 0, 0, 0, 8, 0);
    add_step(op_irq, 0, 'b00, 0, 0, 0);
    add_step(op_read, eth_ctrl_pkg::reg_tx_pending, 1, 0, 0, 0);
    add_step(op_write, eth_ctrl_pkg::reg_tx_pending, 0, 'hF, 0, 0);
    // receive path.
    add_step(op_write, eth_ctrl_pkg::reg_rx_int_en, 1, 'hF, 0, 0);
    add_step(op_inject, 0, 0, 0, 22, 'b010);
    add_step(op_irq, 0, 'b01, 0, 0, 0);
    add_step(op_read, eth_ctrl_pkg::reg_rx_size, 22, 0, 0, 0);
    add_step(op_read, 'h0000, 0, 0, 0, 'b001);
    add_step(op_read, 'h0004, 0, 0, 0, 'b001);
    add_step(op_read, 'h0014, 0, 0, 0, 'b001);
    add_step(op_write, eth_ctrl_pkg::reg_rx_ack, 0, 'hF, 0, 0);
    add_step(op_irq, 0, 'b00, 0, 0, 0);
    add_step(op_read, eth_ctrl_pkg::reg_rx_pending, 0, 0, 0, 0);
    // bad and oversize frames.
    add_step(op_inject, 0, 0, 0, 9, 'b001);
    add_step(op_irq, 0, 'b00, 0, 0, 0);
    add_step(op_read, eth_ctrl_pkg::reg_debug, 1, 0, 0, 0);
    add_step(op_inject, 0, 0, 0, 2060, 'b000);
    add_step(op_read, eth_ctrl_pkg::reg_debug, 2, 0, 0, 0);
    add_step(op_read, eth_ctrl_pkg::reg_rx_pending, 0, 0, 0, 0);
    add_step(op_inject, 0, 0, 0, 13, 'b010);
    add_step(op_irq, 0, 'b01, 0, 0, 0);
    add_step(op_read, eth_ctrl_pkg::reg_rx_size, 13, 0, 0, 0);
    add_step(op_read, 'h0008, 0, 0, 0, 'b001);
    add_step(op_read, 'h000C, 0, 0, 0, 'b001);
    // back-pressure while the 13 byte frame is held.
    add_step(op_offer, 0, 0, 0, 17, 0);
    add_step(op_write, eth_ctrl_pkg::reg_rx_ack, 0, 'hF, 0, 0);
    add_step(op_inject, 0, 0, 0, 17, 'b110);
    add_step(op_read, eth_ctrl_pkg::reg_rx_size, 17, 0, 0, 0);
    add_step(op_read, 'h0000, 0, 0, 0, 'b001);
    add_step(op_read, 'h0010, 0, 0, 0, 'b001);
    add_step(op_write, eth_ctrl_pkg::reg_rx_ack, 0, 'hF, 0, 0);
    add_step(op_read, eth_ctrl_pkg::reg_rx_pending, 0, 0, 0, 0);
  endtask

  initial begin
    int total_beats;
    int limit;
    int e0;
    int i;
    lcg_state    = 32'h95fb_b013;
    errors       = 0;
    checks       = 0;
    rst_n_i      = 1'b0;
    addr_i       = '0;
    write_en_i   = 1'b0;
    read_en_i    = 1'b0;
    write_mask_i = '0;
    write_data_i = '0;
    tx_ready_i   = 1'b0;
    rx_beat_i    = '0;
    rx_valid_i   = 1'b0;
    load_table();
    total_beats = 0;
    for (i = 0; i < steps.size(); i++) begin
      if (steps[i].kind inside {op_send, op_inject, op_offer}) begin
        total_beats += (steps[i].len + 3) / 4;
      end
    end
    limit = (200 * steps.size() + total_beats) * 4;
    fork
      begin
        repeat (limit) @(posedge clk_i);
        $display("watchdog expired after %0d cycles, the run did not finish", limit);
        $display("FAIL: see errors above");
        $finish;
      end
    join_none
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    e0 = errors;
    check_flag(tx_valid_o, 1'b0, "tx_valid_o after reset");
    check_flag(rx_interrupt_o, 1'b0, "rx_interrupt_o after reset");
    check_flag(tx_interrupt_o, 1'b0, "tx_interrupt_o after reset");
    check_flag(rx_ready_o, 1'b1, "rx_ready_o after reset");
    check_word(read_data_o, 32'h0, "read_data_o after reset");
    $display("test reset outputs: %s", (errors == e0) ? "ok" : "FAILED");
    for (i = 0; i < steps.size(); i++) begin
      e0 = errors;
      apply_step(steps[i]);
      $display("test %0d %s: %s", i, steps[i].kind.name(), (errors == e0) ? "ok" : "FAILED");
    end
    $display("%0d tests, %0d checks, %0d errors", steps.size() + 1, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== project.f ====
src/eth_ctrl_pkg.sv
src/ethernet_control_unit.sv
src/ethernet_sender.sv
src/ethernet_receiver.sv
src/interrupt_control_unit.sv
src/ethernet_controller.sv
dv/ethernet_controller_tb.sv

// ==== Bender.yml ====
package:
  name: ethernet_controller

sources:
  - files:
      - src/eth_ctrl_pkg.sv
      - src/ethernet_control_unit.sv
      - src/ethernet_sender.sv
      - src/ethernet_receiver.sv
      - src/interrupt_control_unit.sv
      - src/ethernet_controller.sv
  - target: test
    files:
      - dv/ethernet_controller_tb.sv
